// ==== flist.f ====
+incdir+hdl
hdl/scope_pkg.sv
hdl/sample_timer.sv
hdl/channel_sequencer.sv
hdl/capture_buffer.sv
hdl/wb_scope_regs.sv
hdl/scope_top.sv
verif/scope_checker.sv
verif/scope_tb.sv

// ==== Bender.yml ====
package:
  name: scope

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/scope_pkg.sv
      - hdl/sample_timer.sv
      - hdl/channel_sequencer.sv
      - hdl/capture_buffer.sv
      - hdl/wb_scope_regs.sv
      - hdl/scope_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/scope_checker.sv
      - verif/scope_tb.sv

// ==== verif/scope_tb.sv ====
/*
 * Capture scope testbench.
 * Applies a table of bus accesses and waits to the scope and lets the
 * checker judge every row.
 */
`timescale 1ns/10ps
`include "scope_consts.svh"

module scope_tb;

    import scope_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam logic [1:0]  OP_WRITE    = 2'd0;
    localparam logic [1:0]  OP_READ     = 2'd1;
    localparam logic [1:0]  OP_WAIT     = 2'd2;
    localparam logic [31:0] CTRL_EN     = 32'h01;
    localparam logic [31:0] CTRL_ARM    = 32'h80;
    localparam logic [31:0] MASK_ALL    = 32'h7E;
    localparam logic [31:0] MASK_SPARSE = {25'b0, 6'b100101, 1'b0};
    localparam logic [31:0] STAT_ARMED  = {30'b0, CAP_ARMED};
    localparam logic [31:0] STAT_FULL   = {19'b0, 5'(`SCOPE_DEPTH), 6'b0, CAP_FULL};

    typedef struct packed {
        logic [1:0]   op;
        logic [1:0]   adr;
        logic [31:0]  data;
        channel_bus_t ch;
        logic [31:0]  exp;
        logic         predict;
    } row_t;

    logic         clock;
    logic         arst_n;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    channel_bus_t channels;
    int           row_id;
    logic         row_done;
    logic [31:0]  exp_data;
    logic         predict;
    int           pass_count;
    int           fail_count;
    logic         table_ready;
    row_t         rows[$];
    channel_bus_t set_a;
    channel_bus_t set_b;
    channel_bus_t cur_set;
    int           seed = 89;

    scope_top u_scope_top (
        .clock    (clock),
        .arst_n   (arst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .channels (channels)
    );

    scope_checker u_scope_checker (
        .clock      (clock),
        .arst_n     (arst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .channels   (channels),
        .row_id     (row_id),
        .row_done   (row_done),
        .exp_data   (exp_data),
        .predict    (predict),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    task automatic add_row(input logic [1:0] op, input logic [1:0] adr, input logic [31:0] data,
                           input logic [31:0] exp, input logic pred);
        rows.push_back('{op, adr, data, cur_set, exp, pred});
    endtask

    // Disable first so the timer starts the capture from count zero
    task automatic add_capture(input logic [31:0] mask, input int cycles);
        add_row(OP_WRITE, REG_CTRL, 32'h0, 32'h0, 1'b0);
        add_row(OP_WRITE, REG_CTRL, CTRL_EN | mask | CTRL_ARM, 32'h0, 1'b0);
        add_row(OP_WAIT, REG_CTRL, cycles, 32'h0, 1'b0);
        add_row(OP_READ, REG_STATUS, 32'h0, STAT_FULL, 1'b0);
    endtask

    task automatic add_drain();
        for (int n = 0; n < `SCOPE_DEPTH; n++) begin
            add_row(OP_READ, REG_DATA, 32'h0, 32'h0, 1'b1);
        end
        add_row(OP_READ, REG_DATA, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic build_table();
        for (int k = 0; k < `SCOPE_N_CHANNELS; k++) begin
            set_a[k] = 16'($random(seed));
            set_b[k] = 16'($random(seed));
        end
        cur_set = '0;
        add_row(OP_READ, REG_CTRL, 32'h0, 32'h0, 1'b0);
        add_row(OP_READ, REG_PERIOD, 32'h0, `SCOPE_PERIOD_RST, 1'b0);
        add_row(OP_READ, REG_STATUS, 32'h0, 32'h0, 1'b0);
        add_row(OP_WRITE, REG_PERIOD, 32'd40, 32'h0, 1'b0);
        add_row(OP_READ, REG_PERIOD, 32'h0, 32'd40, 1'b0);
        add_row(OP_WRITE, REG_PERIOD, 32'd5, 32'h0, 1'b0);
        add_row(OP_READ, REG_PERIOD, 32'h0, 32'd16, 1'b0);
        add_row(OP_WRITE, REG_PERIOD, 32'd32, 32'h0, 1'b0);
        cur_set = set_a;
        add_capture(MASK_ALL, 110);
        add_drain();
        add_capture(MASK_SPARSE, 200);
        add_drain();
        // Arm with the timer stopped, nothing may arrive
        add_row(OP_WRITE, REG_CTRL, 32'h0, 32'h0, 1'b0);
        add_row(OP_WRITE, REG_CTRL, MASK_ALL | CTRL_ARM, 32'h0, 1'b0);
        add_row(OP_WAIT, REG_CTRL, 32'd100, 32'h0, 1'b0);
        add_row(OP_READ, REG_STATUS, 32'h0, STAT_ARMED, 1'b0);
        add_row(OP_READ, REG_CTRL, 32'h0, MASK_ALL, 1'b0);
        // Fill the buffer, then re-arm it with new channel values
        add_capture(MASK_ALL, 110);
        cur_set = set_b;
        add_capture(MASK_ALL, 110);
        add_drain();
    endtask

    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] data);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: data};
        @(posedge clock);
        while (!wb_rsp.ack) begin
            @(posedge clock);
        end
        #2;
        wb_req = '0;
    endtask

    task automatic run_row(input int i);
        channels = rows[i].ch;
        exp_data = rows[i].exp;
        predict  = rows[i].predict;
        row_id   = i;
        case (rows[i].op)
            OP_WRITE: bus_access(1'b1, rows[i].adr, rows[i].data);
            OP_READ:  bus_access(1'b0, rows[i].adr, 32'h0);
            default: begin
                repeat (rows[i].data) @(posedge clock);
                #2;
            end
        endcase
        row_done = 1'b1;
        @(posedge clock);
        #2;
        row_done = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        wb_req      = '0;
        channels    = '0;
        row_id      = 0;
        row_done    = 1'b0;
        exp_data    = '0;
        predict     = 1'b0;
        arst_n      = 1'b0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clock);
        #2;
        arst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(i);
        end
        $display("Rows passed: %0d, rows failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == rows.size()) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(rows.size() * 200 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", rows.size() * 200);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verif/scope_checker.sv ====
/*
 * Scope checker.
 * Watches the Wishbone bus and the channel inputs, models the captured
 * words from the mask and reports one line per table row.
 */
`timescale 1ns/10ps
`include "scope_consts.svh"

module scope_checker (
    input  logic                    clock,
    input  logic                    arst_n,
    input  scope_pkg::wb_req_t      wb_req,
    input  scope_pkg::wb_rsp_t      wb_rsp,
    input  scope_pkg::channel_bus_t channels,
    input  int                      row_id,
    input  logic                    row_done,
    input  logic [31:0]             exp_data,
    input  logic                    predict,
    output int                      pass_count,
    output int                      fail_count
);

    import scope_pkg::*;

    logic [`SCOPE_N_CHANNELS-1:0] mask;
    channel_bus_t                 chan_copy;
    int                           read_idx;
    int                           stb_cycles;
    int                           row_errors;
    logic [31:0]                  expected;

    // Entry n of a full capture comes from the (n mod m)-th masked channel
    function automatic logic [31:0] predict_word(input int idx);
        int          seen;
        logic [31:0] word;
        seen = 0;
        word = '0;
        for (int k = 0; k < `SCOPE_N_CHANNELS; k++) begin
            if (mask[k] && idx < `SCOPE_DEPTH && seen == idx % $countones(mask)) begin
                word = {1'b1, 12'b0, 3'(k), chan_copy[k]};
            end
            seen += mask[k];
        end
        return word;
    endfunction

    task automatic report_failure(input string msg);
        $display("Fail at %0t: row %0d %s", $time, row_id, msg);
        row_errors++;
    endtask

    always @(posedge clock) begin
        if (!arst_n) begin
            mask       = '0;
            chan_copy  = '0;
            read_idx   = 0;
            stb_cycles = 0;
            row_errors = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (wb_rsp.ack && !(wb_req.cyc && wb_req.stb)) begin
                report_failure("ack seen with no request pending");
            end
            if (wb_req.cyc && wb_req.stb) begin
                stb_cycles++;
                if (wb_rsp.ack) begin
                    if (stb_cycles != 2) begin
                        report_failure($sformatf("ack after %0d cycles, expected 2", stb_cycles));
                    end
                    if (wb_req.we && wb_req.adr == REG_CTRL) begin
                        mask = wb_req.dat[`SCOPE_N_CHANNELS:1];
                        // Arm starts a new capture of the inputs as they stand now
                        if (wb_req.dat[7]) begin
                            read_idx  = 0;
                            chan_copy = channels;
                        end
                    end else if (!wb_req.we) begin
                        expected = predict ? predict_word(read_idx) : exp_data;
                        if (wb_req.adr == REG_DATA) begin
                            read_idx++;
                        end
                        if (wb_rsp.dat !== expected) begin
                            report_failure($sformatf("read %08h, expected %08h",
                                                     wb_rsp.dat, expected));
                        end
                    end
                    stb_cycles = 0;
                end
            end
            if (row_done) begin
                if (row_errors == 0) begin
                    pass_count++;
                    $display("Pass row %0d", row_id);
                end else begin
                    fail_count++;
                    $display("Fail at %0t: row %0d had %0d errors", $time, row_id, row_errors);
                end
                row_errors = 0;
            end
        end
    end

endmodule

// ==== hdl/scope_top.sv ====
/*
 * Multichannel capture scope.
 * Sample timer, channel sequencer, capture buffer and Wishbone
 * register slave joined into one block.
 */
`timescale 1ns/10ps
`include "scope_consts.svh"

module scope_top (
    input  logic                     clock,
    input  logic                     arst_n,
    input  scope_pkg::wb_req_t       wb_req,
    output scope_pkg::wb_rsp_t       wb_rsp,
    input  scope_pkg::channel_bus_t  channels
);

    import scope_pkg::*;

    logic                         enable;
    logic [`SCOPE_N_CHANNELS-1:0] channel_mask;
    logic [15:0]                  period;
    logic [15:0]                  count;
    scope_sample_t                sample;
    logic                         sample_valid;
    logic                         arm;
    logic                         pop;
    scope_sample_t                head;
    logic                         empty;
    capture_state_e               state;
    logic [4:0]                   fill;

    // The slots are decoded from count alone, the period wrap strobe is spare
    sample_timer u_sample_timer (
        .clock  (clock),
        .arst_n (arst_n),
        .enable (enable),
        .period (period),
        .count  (count),
        .wrap   ()
    );

    channel_sequencer u_channel_sequencer (
        .clock        (clock),
        .arst_n       (arst_n),
        .count        (count),
        .channel_mask (channel_mask),
        .channels     (channels),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    capture_buffer u_capture_buffer (
        .clock        (clock),
        .arst_n       (arst_n),
        .arm          (arm),
        .pop          (pop),
        .sample       (sample),
        .sample_valid (sample_valid),
        .head         (head),
        .empty        (empty),
        .state        (state),
        .fill         (fill)
    );

    wb_scope_regs u_wb_scope_regs (
        .clock        (clock),
        .arst_n       (arst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .enable       (enable),
        .channel_mask (channel_mask),
        .period       (period),
        .arm          (arm),
        .pop          (pop),
        .head         (head),
        .empty        (empty),
        .state        (state),
        .fill         (fill)
    );

endmodule

// ==== hdl/wb_scope_regs.sv ====
/*
 * Wishbone register slave.
 * Holds the control and period registers, returns status and buffer
 * data, and acknowledges every access for exactly one cycle.
 */
`timescale 1ns/10ps
`include "scope_consts.svh"

module wb_scope_regs (
    input  logic                          clock,
    input  logic                          arst_n,
    input  scope_pkg::wb_req_t            wb_req,
    output scope_pkg::wb_rsp_t            wb_rsp,
    output logic                          enable,
    output logic [`SCOPE_N_CHANNELS-1:0]  channel_mask,
    output logic [15:0]                   period,
    output logic                          arm,
    output logic                          pop,
    input  scope_pkg::scope_sample_t      head,
    input  logic                          empty,
    input  scope_pkg::capture_state_e     state,
    input  logic [4:0]                    fill
);

    import scope_pkg::*;

    // Shortest period that still holds every channel slot
    localparam logic [15:0] MIN_PERIOD = 16'(`SCOPE_SLOT_BASE + 2 * `SCOPE_N_CHANNELS);

    scope_reg_e  addr;
    logic        ack;
    logic [31:0] dat_r;
    logic        start;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] rd_word;

    // Response bus is built from the ack flop and the read data register
    assign wb_rsp = {ack, dat_r};

    assign addr  = scope_reg_e'(wb_req.adr);
    // An access starts once per request, ack being high blocks a repeat
    assign start = wb_req.cyc && wb_req.stb && !ack;
    assign wr_en = start && wb_req.we;
    assign rd_en = start && !wb_req.we;

    // The buffer moves its read pointer on the same edge that latches head
    assign pop = rd_en && (addr == REG_DATA) && !empty;

    always_comb begin
        case (addr)
            REG_CTRL:   rd_word = {24'b0, 1'b0, channel_mask, enable};
            REG_PERIOD: rd_word = {16'b0, period};
            REG_STATUS: rd_word = {19'b0, fill, 6'b0, state};
            REG_DATA: begin
                if (empty) begin
                    rd_word = '0;
                end else begin
                    rd_word = {1'b1, 12'b0, head.channel, head.value};
                end
            end
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack          <= 1'b0;
            enable       <= 1'b0;
            channel_mask <= '0;
            period       <= 16'(`SCOPE_PERIOD_RST);
            arm          <= 1'b0;
        end else begin
            ack <= start;
            arm <= wr_en && (addr == REG_CTRL) && wb_req.dat[7];
            if (wr_en && (addr == REG_CTRL)) begin
                enable       <= wb_req.dat[0];
                channel_mask <= wb_req.dat[`SCOPE_N_CHANNELS:1];
            end
            if (wr_en && (addr == REG_PERIOD)) begin
                if (wb_req.dat[15:0] < MIN_PERIOD) begin
                    period <= MIN_PERIOD;
                end else begin
                    period <= wb_req.dat[15:0];
                end
            end
        end
    end

    // Read data goes out together with ack
    always_ff @(posedge clock) begin
        if (rd_en) begin
            dat_r <= rd_word;
        end
    end

endmodule

// ==== hdl/capture_buffer.sv ====
/*
 * Capture buffer.
 * Stores tagged samples after an arm until it is full, and hands the
 * oldest entry to the register slave one pop at a time.
 */
`timescale 1ns/10ps
`include "scope_consts.svh"

module capture_buffer (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       arm,
    input  logic                       pop,
    input  scope_pkg::scope_sample_t   sample,
    input  logic                       sample_valid,
    output scope_pkg::scope_sample_t   head,
    output logic                       empty,
    output scope_pkg::capture_state_e  state,
    output logic [4:0]                 fill
);

    import scope_pkg::*;

    localparam int PTR_W = $clog2(`SCOPE_DEPTH);

    scope_sample_t mem [`SCOPE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             take;
    logic [4:0]       fill_next;

    // Samples are only kept while armed, a full buffer drops them
    assign push  = sample_valid && (state == CAP_ARMED) && !arm;
    assign take  = pop && !empty && !arm;
    assign empty = (fill == 5'd0);
    assign head  = mem[rd_ptr];

    always_comb begin
        fill_next = fill;
        if (push && !take) begin
            fill_next = fill + 5'd1;
        end else if (take && !push) begin
            fill_next = fill - 5'd1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state  <= CAP_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else if (arm) begin
            // Arm restarts capture from any state
            state  <= CAP_ARMED;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill_next;

            // Draining a full buffer does not leave CAP_FULL
            case (state)
                CAP_ARMED: begin
                    if (fill_next == 5'(`SCOPE_DEPTH)) begin
                        state <= CAP_FULL;
                    end
                end
                CAP_IDLE,
                CAP_FULL: begin
                    state <= state;
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= sample;
        end
    end

endmodule

// ==== hdl/channel_sequencer.sv ====
/*
 * Channel sequencer.
 * Latches each masked channel input at its own slot of the timer
 * period and emits it as a tagged single-cycle sample strobe.
 */
`timescale 1ns/10ps
`include "scope_consts.svh"

module channel_sequencer (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic [15:0]                    count,
    input  logic [`SCOPE_N_CHANNELS-1:0]   channel_mask,
    input  scope_pkg::channel_bus_t        channels,
    output scope_pkg::scope_sample_t       sample,
    output logic                           sample_valid
);

    import scope_pkg::*;

    localparam int CH_W = $clog2(`SCOPE_N_CHANNELS);

    logic            slot_hit;
    logic [CH_W-1:0] slot_ch;

    // Slots are two counts apart, so at most one channel matches
    always_comb begin
        slot_hit = 1'b0;
        slot_ch  = '0;
        for (int k = 0; k < `SCOPE_N_CHANNELS; k++) begin
            if (count == 16'(`SCOPE_SLOT_BASE + 2 * k)) begin
                slot_hit = 1'b1;
                slot_ch  = CH_W'(k);
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= slot_hit && channel_mask[slot_ch];
        end
    end

    // The value is only meaningful while sample_valid is high
    always_ff @(posedge clock) begin
        if (slot_hit) begin
            sample.channel <= slot_ch;
            sample.value   <= channels[slot_ch];
        end
    end

endmodule

// ==== hdl/sample_timer.sv ====
/*
 * Sample timer.
 * Counts modulo the programmed period while the scope is enabled and
 * pulses wrap on each return to zero.
 */
`timescale 1ns/10ps

module sample_timer (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        enable,
    input  logic [15:0] period,
    output logic [15:0] count,
    output logic        wrap
);

    logic last;

    // The compare uses >= so that a period shortened below the current
    // count still brings the counter back to zero at once
    assign last = (count >= period - 16'd1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            wrap  <= 1'b0;
        end else if (!enable) begin
            count <= '0;
            wrap  <= 1'b0;
        end else if (last) begin
            count <= '0;
            wrap  <= 1'b1;
        end else begin
            count <= count + 16'd1;
            wrap  <= 1'b0;
        end
    end

endmodule

// ==== hdl/scope_pkg.sv ====
/*
 * Capture scope types.
 * Tagged sample, channel input bus, Wishbone request and response
 * structs and the enums for capture state and register addresses.
 */
`include "scope_consts.svh"

package scope_pkg;

    // One captured value tagged with the channel it came from
    typedef struct packed {
        logic [$clog2(`SCOPE_N_CHANNELS)-1:0] channel;
        logic [`SCOPE_SAMPLE_W-1:0]           value;
    } scope_sample_t;

    // All channel inputs side by side, channel 0 in the low slice
    typedef logic [`SCOPE_N_CHANNELS-1:0][`SCOPE_SAMPLE_W-1:0] channel_bus_t;

    // Host to slave side of the Wishbone classic bus
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`SCOPE_ADDR_W-1:0] adr;
        logic [31:0]              dat;
    } wb_req_t;

    // Slave to host side
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        CAP_IDLE  = 2'd0,
        CAP_ARMED = 2'd1,
        CAP_FULL  = 2'd2
    } capture_state_e;

    // Word addresses of the register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_PERIOD = 2'd1,
        REG_STATUS = 2'd2,
        REG_DATA   = 2'd3
    } scope_reg_e;

endpackage

// ==== hdl/scope_consts.svh ====
/*
 * Capture scope constants.
 * Channel count, sample width, buffer depth, slot timing and bus width
 * shared by the scope RTL.
 */
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// Number of external channels sampled in each timer period
`define SCOPE_N_CHANNELS 6

// Width of one channel value
`define SCOPE_SAMPLE_W 16

// Capture buffer entries
`define SCOPE_DEPTH 16

// Timer count of the channel 0 slot, channel k sits at SLOT_BASE + 2*k
`define SCOPE_SLOT_BASE 4

// Sample period loaded at reset
`define SCOPE_PERIOD_RST 32

// Wishbone word address width
`define SCOPE_ADDR_W 2

`endif
